//--- source/uart_pkg.sv
`default_nettype none

// ====================
// Serial line constants
// ====================
package uart_pkg;

   localparam int CLK_HZ       = 50_000_000;  // System clock
   localparam int BAUD_DEFAULT = 115_200;     // Rate selected out of reset
   localparam int OVERSAMPLE   = 16;          // Ticks per bit
   localparam int FIFO_DEPTH   = 8;           // Entries per byte FIFO

   typedef logic [7:0]  byte_t;               // One byte on the line
   typedef logic [15:0] div_t;                // Clocks per oversample tick

   // Rounded divisor for the default rate, 27 at 50 MHz
   localparam div_t DEFAULT_DIV = div_t'((CLK_HZ + OVERSAMPLE * BAUD_DEFAULT / 2)
                                         / (OVERSAMPLE * BAUD_DEFAULT));

   // Tick counter within one bit
   localparam int SUB_W = $clog2(OVERSAMPLE);
   typedef logic [SUB_W-1:0] sub_t;
   localparam sub_t SUB_LAST = sub_t'(OVERSAMPLE - 1);      // Last tick of a bit
   localparam sub_t SUB_MID  = sub_t'(OVERSAMPLE / 2 - 1);  // Start bit centre

   // FIFO pointers and fill level
   localparam int PTR_W = $clog2(FIFO_DEPTH);
   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [PTR_W:0]   count_t;          // One extra bit to hold "full"

endpackage

`default_nettype wire

//--- source/regs_pkg.sv
`default_nettype none

// ====================
// Register map
// ====================
package regs_pkg;

   typedef logic [3:0]  addr_t;   // Byte address within the block
   typedef logic [31:0] data_t;   // Register word
   typedef logic [1:0]  resp_t;   // AXI response code

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   localparam addr_t ADDR_DATA   = 4'h0;  // Write pushes TX, read pops RX
   localparam addr_t ADDR_STATUS = 4'h4;  // Read only
   localparam addr_t ADDR_CTRL   = 4'h8;
   localparam addr_t ADDR_DIV    = 4'hC;

   // STATUS bits
   localparam int STAT_TX_EMPTY  = 0;
   localparam int STAT_TX_FULL   = 1;
   localparam int STAT_RX_VALID  = 2;
   localparam int STAT_FRAME_ERR = 3;  // Sticky
   localparam int STAT_OVERRUN   = 4;  // Sticky
   localparam int STAT_TX_BUSY   = 5;

   // CTRL bits
   localparam int CTRL_LOOPBACK = 0;
   localparam int CTRL_CLEAR    = 1;   // Write 1 clears sticky errors, reads 0

endpackage

`default_nettype wire

//--- source/reg_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// Single-cycle register access between the bus slave and the register block
interface reg_bus_if;

   logic            wr_en;   // Write strobe, one cycle
   logic            rd_en;   // Read strobe, one cycle
   regs_pkg::addr_t addr;
   regs_pkg::data_t wdata;
   regs_pkg::data_t rdata;   // Combinational from addr
   logic            err;     // Unmapped address

   modport slave (
      output wr_en, rd_en, addr, wdata,
      input  rdata, err
   );

   modport regs (
      input  wr_en, rd_en, addr, wdata,
      output rdata, err
   );

endinterface

`default_nettype wire

//--- source/axil_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axil_slave (
   input  wire             clk,
   input  wire             reset,
   // Write address and data
   input  wire             awvalid,
   output logic            awready,
   input  regs_pkg::addr_t awaddr,
   input  wire             wvalid,
   output logic            wready,
   input  regs_pkg::data_t wdata,
   // Write response
   output logic            bvalid,
   input  wire             bready,
   output regs_pkg::resp_t bresp,
   // Read address
   input  wire             arvalid,
   output logic            arready,
   input  regs_pkg::addr_t araddr,
   // Read data
   output logic            rvalid,
   input  wire             rready,
   output regs_pkg::data_t rdata,
   output regs_pkg::resp_t rresp,
   reg_bus_if.slave        bus
);

   logic wr_hs;  // Address and data accepted together
   logic rd_hs;

   assign wr_hs = awvalid && wvalid && !bvalid;
   assign rd_hs = arvalid && !rvalid && !wr_hs;  // Write wins a tie

   assign awready = wr_hs;
   assign wready  = wr_hs;
   assign arready = rd_hs;

   // ====================
   // Register access
   // ====================
   assign bus.wr_en = wr_hs;
   assign bus.rd_en = rd_hs;
   assign bus.addr  = wr_hs ? awaddr : araddr;
   assign bus.wdata = wdata;

   // Pending response flags
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_hs)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rd_hs)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // Response payload, captured at the handshake
   always_ff @(posedge clk) begin
      if (wr_hs)
         bresp <= bus.err ? regs_pkg::RESP_SLVERR : regs_pkg::RESP_OKAY;
      if (rd_hs) begin
         rdata <= bus.rdata;
         rresp <= bus.err ? regs_pkg::RESP_SLVERR : regs_pkg::RESP_OKAY;
      end
   end

   // A response is held steady until the master takes it
   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bresp));
   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- source/uart_regs.sv
`timescale 1ns/10ps
`default_nettype none

module uart_regs (
   input  wire             clk,
   input  wire             reset,
   reg_bus_if.regs         bus,
   output uart_pkg::byte_t tx_data,        // To TX FIFO
   output logic            tx_push,
   input  wire             tx_full,
   input  wire             tx_empty,
   input  uart_pkg::byte_t rx_data,        // From RX FIFO head
   output logic            rx_pop,
   input  wire             rx_valid,
   input  wire             tx_busy,
   input  wire             frame_err_set,  // One-cycle pulses from the receiver
   input  wire             overrun_set,
   output logic            loopback,
   output uart_pkg::div_t  div
);

   logic            frame_err;  // Sticky
   logic            overrun;    // Sticky
   logic            wr_ok;
   logic            clr;
   regs_pkg::data_t status;

   always_comb begin
      status                           = '0;
      status[regs_pkg::STAT_TX_EMPTY]  = tx_empty;
      status[regs_pkg::STAT_TX_FULL]   = tx_full;
      status[regs_pkg::STAT_RX_VALID]  = rx_valid;
      status[regs_pkg::STAT_FRAME_ERR] = frame_err;
      status[regs_pkg::STAT_OVERRUN]   = overrun;
      status[regs_pkg::STAT_TX_BUSY]   = tx_busy;
   end

   // ====================
   // Read decode
   // ====================
   always_comb begin
      bus.rdata = '0;
      bus.err   = 1'b0;
      case (bus.addr)
         regs_pkg::ADDR_DATA:   bus.rdata = rx_valid ? regs_pkg::data_t'(rx_data) : '0;
         regs_pkg::ADDR_STATUS: bus.rdata = status;
         regs_pkg::ADDR_CTRL:   bus.rdata[regs_pkg::CTRL_LOOPBACK] = loopback;
         regs_pkg::ADDR_DIV:    bus.rdata = regs_pkg::data_t'(div);
         default:               bus.err   = 1'b1;  // No side effect either
      endcase
   end

   assign wr_ok = bus.wr_en && !bus.err;
   assign clr   = wr_ok && bus.addr == regs_pkg::ADDR_CTRL
                  && bus.wdata[regs_pkg::CTRL_CLEAR];

   // FIFO strobes, a push on full is dropped
   assign tx_data = bus.wdata[7:0];
   assign tx_push = wr_ok && bus.addr == regs_pkg::ADDR_DATA && !tx_full;
   assign rx_pop  = bus.rd_en && bus.addr == regs_pkg::ADDR_DATA && rx_valid;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         loopback  <= 1'b0;
         div       <= uart_pkg::DEFAULT_DIV;
         frame_err <= 1'b0;
         overrun   <= 1'b0;
      end else begin
         if (wr_ok && bus.addr == regs_pkg::ADDR_CTRL)
            loopback <= bus.wdata[regs_pkg::CTRL_LOOPBACK];
         if (wr_ok && bus.addr == regs_pkg::ADDR_DIV)
            div <= bus.wdata[15:0];
         frame_err <= frame_err_set || (frame_err && !clr);  // New event beats clear
         overrun   <= overrun_set || (overrun && !clr);
      end
   end

endmodule

`default_nettype wire

//--- source/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module byte_fifo (
   input  wire             clk,
   input  wire             reset,
   input  uart_pkg::byte_t in_data,
   input  wire             in_valid,
   output logic            in_ready,
   output uart_pkg::byte_t out_data,
   output logic            out_valid,
   input  wire             out_ready
);

   uart_pkg::byte_t  mem [uart_pkg::FIFO_DEPTH];  // Circular storage
   uart_pkg::ptr_t   wr_ptr;
   uart_pkg::ptr_t   rd_ptr;
   uart_pkg::count_t count;
   logic             push;
   logic             pop;

   assign in_ready  = count != uart_pkg::FIFO_DEPTH;  // Full drops ready
   assign out_valid = count != '0;
   assign out_data  = mem[rd_ptr];                    // Head, visible next cycle

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   // Depth is a power of two, pointers wrap by themselves
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Fill level never passes the depth and never wraps below empty
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      count <= uart_pkg::FIFO_DEPTH);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      count == '0 |=> count <= 1);

endmodule

`default_nettype wire

//--- source/baud_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen (
   input  wire            clk,
   input  wire            reset,
   input  uart_pkg::div_t div,   // Clocks per tick, 0 acts as 1
   output logic           tick   // One cycle wide
);

   uart_pkg::div_t cnt;

   // Down-counter, div is sampled only at reload
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else if (cnt == '0) begin
         cnt  <= (div == '0) ? '0 : div - 1'b1;
         tick <= 1'b1;
      end else begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
   input  wire             clk,
   input  wire             reset,
   input  wire             tick,      // 16x oversample
   input  uart_pkg::byte_t in_data,
   input  wire             in_valid,
   output logic            in_ready,
   output logic            txd,
   output logic            busy
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

   tx_state_t       state;
   uart_pkg::sub_t  sub;       // Tick within the current bit
   logic [2:0]      bit_idx;
   uart_pkg::byte_t shreg;     // LSB goes out first
   logic            bit_end;

   assign bit_end  = tick && sub == uart_pkg::SUB_LAST;
   assign in_ready = state == TX_IDLE && tick;  // Start aligned to a tick, full-length bits
   assign busy     = state != TX_IDLE;

   // Line level from the state, high when idle
   always_comb begin
      case (state)
         TX_START: txd = 1'b0;
         TX_DATA:  txd = shreg[0];
         default:  txd = 1'b1;      // Idle and stop bit
      endcase
   end

   // ====================
   // Frame sequencing
   // ====================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= TX_IDLE;
         sub     <= '0;
         bit_idx <= '0;
      end else begin
         if (state == TX_IDLE)
            sub <= '0;
         else if (tick)
            sub <= bit_end ? '0 : sub + 1'b1;
         case (state)
            TX_IDLE:  if (in_valid && in_ready) state <= TX_START;
            TX_START: if (bit_end) begin
               state   <= TX_DATA;
               bit_idx <= '0;
            end
            TX_DATA:  if (bit_end) begin
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 3'd7)
                  state <= TX_STOP;
            end
            TX_STOP:  if (bit_end) state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready)
         shreg <= in_data;               // Load on handshake
      else if (state == TX_DATA && bit_end)
         shreg <= shreg >> 1;            // Next bit to position 0
   end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
   input  wire             clk,
   input  wire             reset,
   input  wire             tick,       // 16x oversample
   input  wire             rxd,        // Asynchronous line
   output uart_pkg::byte_t out_data,
   output logic            out_valid,  // One-cycle push
   input  wire             out_ready,
   output logic            frame_err,  // Pulse on low stop bit
   output logic            overrun     // Pulse on push into a full FIFO
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t       state;
   logic            rxd_meta;
   logic            rxd_sync;
   uart_pkg::sub_t  sub;
   logic [2:0]      bit_idx;
   uart_pkg::byte_t shreg;
   logic            sample;      // Mid-bit of a data bit

   // Two-flop synchronizer, resets to idle level
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   assign sample   = tick && state == RX_DATA && sub == uart_pkg::SUB_LAST;
   assign out_data = shreg;
   assign overrun  = out_valid && !out_ready;  // Byte is lost in the FIFO

   // ====================
   // Receive FSM
   // ====================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= RX_IDLE;
         sub       <= '0;
         bit_idx   <= '0;
         out_valid <= 1'b0;
         frame_err <= 1'b0;
      end else begin
         out_valid <= 1'b0;
         frame_err <= 1'b0;
         if (tick) begin
            case (state)
               RX_IDLE: if (!rxd_sync) begin   // Falling edge is tick 0
                  state <= RX_START;
                  sub   <= '0;
               end
               RX_START: if (sub == uart_pkg::SUB_MID) begin
                  sub     <= '0;
                  bit_idx <= '0;
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Glitch goes back
               end else begin
                  sub <= sub + 1'b1;
               end
               RX_DATA: if (sub == uart_pkg::SUB_LAST) begin
                  sub     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end else begin
                  sub <= sub + 1'b1;
               end
               RX_STOP: if (sub == uart_pkg::SUB_LAST) begin
                  state     <= RX_IDLE;     // Mid stop bit
                  out_valid <= rxd_sync;
                  frame_err <= !rxd_sync;   // Byte discarded
               end else begin
                  sub <= sub + 1'b1;
               end
               default: state <= RX_IDLE;
            endcase
         end
      end
   end

   // LSB arrives first, shift in at the top
   always_ff @(posedge clk) begin
      if (sample)
         shreg <= {rxd_sync, shreg[7:1]};
   end

endmodule

`default_nettype wire

//--- source/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top (
   input  wire             clk,
   input  wire             reset,
   input  wire             awvalid,
   output logic            awready,
   input  regs_pkg::addr_t awaddr,
   input  wire             wvalid,
   output logic            wready,
   input  regs_pkg::data_t wdata,
   output logic            bvalid,
   input  wire             bready,
   output regs_pkg::resp_t bresp,
   input  wire             arvalid,
   output logic            arready,
   input  regs_pkg::addr_t araddr,
   output logic            rvalid,
   input  wire             rready,
   output regs_pkg::data_t rdata,
   output regs_pkg::resp_t rresp,
   input  wire             uart_rx,   // Serial in
   output logic            uart_tx    // Serial out
);

   reg_bus_if bus ();

   uart_pkg::byte_t tx_wr_data, tx_rd_data, rx_wr_data, rx_rd_data;
   logic            tx_push, tx_in_ready, tx_out_valid, tx_out_ready;
   logic            rx_push, rx_in_ready, rx_out_valid, rx_pop;
   logic            tick, txd, rxd, tx_busy, frame_err, overrun, loopback;
   uart_pkg::div_t  div;

   // ====================
   // Loopback mux
   // ====================
   assign rxd     = loopback ? txd : uart_rx;
   assign uart_tx = loopback ? 1'b1 : txd;  // Pin parked at idle

   axil_slave u_axil (
      .clk, .reset,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .bus (bus.slave)
   );

   uart_regs u_regs (
      .clk, .reset,
      .bus           (bus.regs),
      .tx_data       (tx_wr_data),
      .tx_push       (tx_push),
      .tx_full       (!tx_in_ready),
      .tx_empty      (!tx_out_valid),
      .rx_data       (rx_rd_data),
      .rx_pop        (rx_pop),
      .rx_valid      (rx_out_valid),
      .tx_busy       (tx_busy),
      .frame_err_set (frame_err),
      .overrun_set   (overrun),
      .loopback      (loopback),
      .div           (div)
   );

   byte_fifo u_tx_fifo (
      .clk, .reset,
      .in_data (tx_wr_data), .in_valid (tx_push), .in_ready (tx_in_ready),
      .out_data (tx_rd_data), .out_valid (tx_out_valid), .out_ready (tx_out_ready)
   );

   byte_fifo u_rx_fifo (
      .clk, .reset,
      .in_data (rx_wr_data), .in_valid (rx_push), .in_ready (rx_in_ready),
      .out_data (rx_rd_data), .out_valid (rx_out_valid), .out_ready (rx_pop)
   );

   baud_tick_gen u_baud (.clk, .reset, .div (div), .tick (tick));

   uart_tx u_tx (
      .clk, .reset, .tick,
      .in_data (tx_rd_data), .in_valid (tx_out_valid), .in_ready (tx_out_ready),
      .txd (txd), .busy (tx_busy)
   );

   uart_rx u_rx (
      .clk, .reset, .tick,
      .rxd (rxd),
      .out_data (rx_wr_data), .out_valid (rx_push), .out_ready (rx_in_ready),
      .frame_err (frame_err), .overrun (overrun)
   );

endmodule

`default_nettype wire

//--- testbench/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

   localparam int RUN_DIV       = 2;                              // Fast baud for the run
   localparam int BIT_CLKS      = uart_pkg::OVERSAMPLE * RUN_DIV; // Clocks per serial bit
   localparam int EXP_DIV       = 27;                             // 115200 baud at 50 MHz
   localparam int AXI_TIMEOUT   = 20;                             // Cycles per handshake
   localparam int FRAME_TIMEOUT = 20 * BIT_CLKS;                  // Two frame times
   localparam int POLL_LIMIT    = 500;
   localparam int MAX_STEPS     = 96;

   localparam regs_pkg::data_t ST_EMPTY = 32'h1 << regs_pkg::STAT_TX_EMPTY;
   localparam regs_pkg::data_t ST_RXV   = 32'h1 << regs_pkg::STAT_RX_VALID;
   localparam regs_pkg::data_t ST_FERR  = 32'h1 << regs_pkg::STAT_FRAME_ERR;
   localparam regs_pkg::data_t ST_OVR   = 32'h1 << regs_pkg::STAT_OVERRUN;
   localparam regs_pkg::data_t ST_BUSY  = 32'h1 << regs_pkg::STAT_TX_BUSY;
   localparam regs_pkg::resp_t OKAY     = regs_pkg::RESP_OKAY;
   localparam regs_pkg::resp_t SLVERR   = regs_pkg::RESP_SLVERR;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_SEND, OP_EXPECT} op_t;

   // POLL uses data as a mask, SEND carries the stop level in bit 8
   typedef struct packed {
      op_t             op;
      regs_pkg::addr_t addr;
      regs_pkg::data_t data;
      regs_pkg::resp_t resp;
      regs_pkg::data_t exp;
   } step_t;

   logic clk, reset;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   regs_pkg::addr_t awaddr, araddr;
   regs_pkg::data_t wdata, rdata;
   regs_pkg::resp_t bresp, rresp;
   logic uart_rx, uart_tx;

   step_t      steps [MAX_STEPS];
   int         n_steps;
   logic [8:0] tx_seen [$];  // Decoded frames, stop bit on top

   uart_top dut_i (
      .clk, .reset,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .uart_rx, .uart_tx
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 100 MHz in simulation
   end

   // ====================
   // Checks and failures
   // ====================
   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("Test failed");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      $display("Test failed");
      $fatal(1, "stopping on timeout");
   endtask

   // ====================
   // AXI4-Lite master
   // ====================
   task automatic axi_write(input regs_pkg::addr_t addr, input regs_pkg::data_t data,
                            output regs_pkg::resp_t resp);
      int n;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      n = 0;
      @(negedge clk);
      while (!(awready && wready)) begin
         if (n == AXI_TIMEOUT) fail_timeout("awready and wready");
         n++;
         @(negedge clk);
      end
      @(posedge clk);                   // Handshake edge
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      n = 0;
      @(negedge clk);
      while (!bvalid) begin
         if (n == AXI_TIMEOUT) fail_timeout("bvalid");
         n++;
         @(negedge clk);
      end
      check_value("write response latency", n, 0);  // One cycle after the handshake
      resp = bresp;
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axi_read(input regs_pkg::addr_t addr, output regs_pkg::data_t data,
                           output regs_pkg::resp_t resp);
      int n;
      araddr  = addr;
      arvalid = 1'b1;
      n = 0;
      @(negedge clk);
      while (!arready) begin
         if (n == AXI_TIMEOUT) fail_timeout("arready");
         n++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      rready  = 1'b1;
      n = 0;
      @(negedge clk);
      while (!rvalid) begin
         if (n == AXI_TIMEOUT) fail_timeout("rvalid");
         n++;
         @(negedge clk);
      end
      check_value("read response latency", n, 0);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   // ====================
   // Serial side
   // ====================
   // Start, 8 data bits LSB first, stop, then one idle bit so the receiver re-arms
   task automatic send_frame(input logic [7:0] b, input logic stop);
      uart_rx = 1'b0;
      repeat (BIT_CLKS) @(posedge clk);
      #1;
      for (int k = 0; k < 8; k++) begin
         uart_rx = b[k];
         repeat (BIT_CLKS) @(posedge clk);
         #1;
      end
      uart_rx = stop;
      repeat (BIT_CLKS) @(posedge clk);
      #1;
      uart_rx = 1'b1;
      repeat (BIT_CLKS) @(posedge clk);
      #1;
   endtask

   // Decoder on uart_tx, sampled at falling edges to stay clear of the DUT's edge
   initial begin : tx_decoder
      logic [7:0] b;
      logic       stop_bit;
      forever begin
         @(negedge clk);
         if (uart_tx === 1'b0) begin
            repeat (BIT_CLKS / 2 - 1) @(negedge clk);  // Middle of start bit
            check_value("start bit on uart_tx", uart_tx, 0);
            for (int k = 0; k < 8; k++) begin
               repeat (BIT_CLKS) @(negedge clk);
               b[k] = uart_tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            stop_bit = uart_tx;
            tx_seen.push_back({stop_bit, b});
         end
      end
   end

   task automatic next_tx_frame(output logic [8:0] frame);
      int n;
      n = 0;
      while (tx_seen.size() == 0) begin
         if (n == FRAME_TIMEOUT) fail_timeout("a frame on uart_tx");
         n++;
         @(posedge clk);
         #1;
      end
      frame = tx_seen.pop_front();
   endtask

   // ====================
   // Stimulus table
   // ====================
   function automatic void add_step(input op_t op, input regs_pkg::addr_t addr,
                                    input regs_pkg::data_t data, input regs_pkg::resp_t resp,
                                    input regs_pkg::data_t exp);
      step_t s;
      s.op   = op;
      s.addr = addr;
      s.data = data;
      s.resp = resp;
      s.exp  = exp;
      steps[n_steps] = s;
      n_steps++;
   endfunction

   function automatic void build_table();
      logic [7:0] tx_bytes [4];
      logic [7:0] rx_bytes [uart_pkg::FIFO_DEPTH + 1];
      n_steps = 0;
      // Reset values
      add_step(OP_READ,  regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY);
      add_step(OP_READ,  regs_pkg::ADDR_DIV,    0, OKAY, EXP_DIV);
      add_step(OP_READ,  regs_pkg::ADDR_CTRL,   0, OKAY, 0);
      // Register access
      add_step(OP_WRITE, regs_pkg::ADDR_DIV,    RUN_DIV, OKAY, 0);
      add_step(OP_READ,  regs_pkg::ADDR_DIV,    0, OKAY, RUN_DIV);
      add_step(OP_WRITE, regs_pkg::ADDR_CTRL,   32'h3, OKAY, 0);  // Clear bit reads back 0
      add_step(OP_READ,  regs_pkg::ADDR_CTRL,   0, OKAY, 32'h1);
      add_step(OP_WRITE, regs_pkg::ADDR_CTRL,   32'h0, OKAY, 0);
      add_step(OP_READ,  regs_pkg::ADDR_CTRL,   0, OKAY, 0);
      add_step(OP_WRITE, 4'h2, 32'h55, SLVERR, 0);                  // Outside the map
      add_step(OP_READ,  4'h6, 0, SLVERR, 0);
      add_step(OP_READ,  regs_pkg::ADDR_DIV,    0, OKAY, RUN_DIV);
      add_step(OP_WRITE, regs_pkg::ADDR_STATUS, 32'hFF, OKAY, 0);    // Read only
      add_step(OP_READ,  regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY);
      // Transmit, four bytes back to back, then their frames in order
      for (int k = 0; k < 4; k++) begin
         tx_bytes[k] = 8'($urandom());
         add_step(OP_WRITE, regs_pkg::ADDR_DATA, tx_bytes[k], OKAY, 0);
      end
      for (int k = 0; k < 4; k++)
         add_step(OP_EXPECT, 4'h0, 0, OKAY, {23'h0, 1'b1, tx_bytes[k]});
      add_step(OP_POLL, regs_pkg::ADDR_STATUS, ST_EMPTY | ST_BUSY, OKAY, ST_EMPTY);
      // Loopback
      add_step(OP_WRITE, regs_pkg::ADDR_CTRL, 32'h1, OKAY, 0);
      for (int k = 0; k < 3; k++) begin
         rx_bytes[k] = 8'($urandom());
         add_step(OP_WRITE, regs_pkg::ADDR_DATA, rx_bytes[k], OKAY, 0);
      end
      add_step(OP_POLL, regs_pkg::ADDR_STATUS, ST_EMPTY | ST_BUSY, OKAY, ST_EMPTY);
      add_step(OP_READ, regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY | ST_RXV);
      for (int k = 0; k < 3; k++)
         add_step(OP_READ, regs_pkg::ADDR_DATA, 0, OKAY, rx_bytes[k]);
      add_step(OP_READ,  regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY);
      add_step(OP_WRITE, regs_pkg::ADDR_CTRL, 32'h0, OKAY, 0);
      // Receive errors, low stop bit first
      add_step(OP_SEND, 4'h0, 32'h0A5, OKAY, 0);
      add_step(OP_READ, regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY | ST_FERR);
      for (int k = 0; k <= uart_pkg::FIFO_DEPTH; k++) begin
         rx_bytes[k] = 8'($urandom());
         add_step(OP_SEND, 4'h0, {23'h0, 1'b1, rx_bytes[k]}, OKAY, 0);
      end
      add_step(OP_READ, regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY | ST_RXV | ST_FERR | ST_OVR);
      for (int k = 0; k < uart_pkg::FIFO_DEPTH; k++)
         add_step(OP_READ, regs_pkg::ADDR_DATA, 0, OKAY, rx_bytes[k]);
      add_step(OP_READ,  regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY | ST_FERR | ST_OVR);
      add_step(OP_READ,  regs_pkg::ADDR_DATA,   0, OKAY, 0);  // Empty FIFO reads 0
      add_step(OP_WRITE, regs_pkg::ADDR_CTRL,   32'h2, OKAY, 0);
      add_step(OP_READ,  regs_pkg::ADDR_STATUS, 0, OKAY, ST_EMPTY);
      add_step(OP_READ,  regs_pkg::ADDR_CTRL,   0, OKAY, 0);
   endfunction

   // ====================
   // Main sequence
   // ====================
   initial begin : main
      regs_pkg::data_t data;
      regs_pkg::resp_t resp;
      logic [8:0]      frame;
      int              polls;
      reset   = 1'b1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      araddr  = '0;
      wdata   = '0;
      uart_rx = 1'b1;   // Line idles high
      void'($urandom(11));
      build_table();
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value("uart_tx after reset", uart_tx, 1);
      check_value("bvalid after reset", bvalid, 0);
      check_value("rvalid after reset", rvalid, 0);
      for (int i = 0; i < n_steps; i++) begin
         case (steps[i].op)
            OP_WRITE: begin
               axi_write(steps[i].addr, steps[i].data, resp);
               check_value($sformatf("step %0d bresp", i), resp, steps[i].resp);
            end
            OP_READ: begin
               axi_read(steps[i].addr, data, resp);
               check_value($sformatf("step %0d rresp", i), resp, steps[i].resp);
               check_value($sformatf("step %0d rdata", i), data, steps[i].exp);
            end
            OP_POLL: begin
               polls = 0;
               axi_read(steps[i].addr, data, resp);
               while ((data & steps[i].data) !== steps[i].exp) begin
                  if (polls == POLL_LIMIT) fail_timeout($sformatf("status in step %0d", i));
                  polls++;
                  axi_read(steps[i].addr, data, resp);
               end
            end
            OP_SEND: send_frame(steps[i].data[7:0], steps[i].data[8]);
            default: begin
               next_tx_frame(frame);
               check_value($sformatf("step %0d frame on uart_tx", i), frame, steps[i].exp);
            end
         endcase
      end
      check_value("extra frames on uart_tx", tx_seen.size(), 0);  // Also covers loopback
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
source/uart_pkg.sv
source/regs_pkg.sv
source/reg_bus_if.sv
source/axil_slave.sv
source/uart_regs.sv
source/byte_fifo.sv
source/baud_tick_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
testbench/uart_tb.sv
